//--- logic/bus60x_pkg.sv
// shared widths, transfer types and bus drive structs; imported by every bus module
package bus60x_pkg;

   localparam int addr_w      = 32;                    // address bus width
   localparam int data_w      = 64;                    // data bus width, one double word
   localparam int mem_words   = 256;                   // memory depth in double words
   localparam int burst_beats = 4;                     // beats in a burst data tenure
   localparam int aack_lat    = 2;                     // ts to aack in cycles
   localparam int beat_w      = $clog2(burst_beats);   // beat counter width
   localparam int widx_w      = $clog2(mem_words);     // memory word index width
   localparam int dw_lsb      = $clog2(data_w / 8);    // byte offset bits inside a double word
   localparam int lat_w       = $clog2(aack_lat + 1);  // aack delay counter width

   // 60x style codes: bit 3 set for reads, bit 2 set for bursts
   typedef enum logic [4:0] {
      tt_write       = 5'b00010,
      tt_write_burst = 5'b00110,
      tt_read        = 5'b01010,
      tt_read_burst  = 5'b01110
   } tt_e;

   typedef enum logic [1:0] {
      arb_idle,                                        // address bus free
      arb_granted,                                     // bg out for one cycle
      arb_tenure                                       // waiting for aack
   } arb_state_e;

   typedef struct packed {
      logic              ts;                           // transfer start
      logic              abb;                          // address bus busy
      tt_e               tt;                           // transfer type
      logic [addr_w-1:0] addr;
      logic [3:0]        ap;                           // odd parity, one bit per address byte
   } addr_bus_s;

   typedef struct packed {
      logic              dbb;                          // data bus busy
      logic [data_w-1:0] data;
      logic              with_data;                    // write data valid on data
   } data_bus_s;

   typedef struct packed {
      tt_e                                 tt;
      logic [addr_w-1:0]                   addr;
      logic [burst_beats-1:0][data_w-1:0]  wdata;      // singles use beat 0
   } cmd_s;

   function automatic logic [3:0] addr_parity(input logic [addr_w-1:0] addr);
      logic [3:0] p;
      for (int i = 0; i < 4; i++) begin
         p[i] = ~^addr[8*i +: 8];                      // odd parity per byte
      end
      return p;
   endfunction

   function automatic logic is_burst(input tt_e tt);
      return tt[2];
   endfunction

   function automatic logic is_write(input tt_e tt);
      return !tt[3];
   endfunction

endpackage

//--- logic/bus_arbiter.sv
// address and data bus arbiter for two masters; grants bg round robin and orders dbg by aack
`timescale 1ns/100ps

module bus_arbiter import bus60x_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [1:0] br,                                   // bus requests
   input  logic       ts,                                   // merged transfer start
   input  logic       abb,                                  // merged address bus busy
   input  logic       aack,
   input  logic       ta,
   input  logic       burst,                                // merged tt is a burst
   output logic [1:0] bg,
   output logic [1:0] dbg
);

   arb_state_e        state;
   logic              owner;                                // master holding the address bus
   logic              last_gnt;                             // master granted last
   logic              sel;                                  // round robin pick
   logic [1:0]        q_idx;                                // data queue master index, [0] is head
   logic [1:0]        q_bst;                                // data queue burst flag
   logic [1:0]        q_cnt;                                // acknowledged tenures queued
   logic [1:0]        q_cnt_pop;                            // count once the head has left
   logic [beat_w-1:0] beat;                                 // beats done in the head tenure
   logic              push;
   logic              last_beat;
   logic              wr_slot;                              // queue slot for the push

   // the master not granted last wins a tie
   always_comb begin
      if (br[0] && br[1]) begin
         sel = ~last_gnt;
      end else begin
         sel = br[1];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= arb_idle;
         owner    <= 1'b0;
         last_gnt <= 1'b1;                                  // so master 0 goes first
      end else begin
         case (state)
            arb_idle: begin
               if (|br && !abb && !ts) begin                // bus parked and quiet
                  state    <= arb_granted;
                  owner    <= sel;
                  last_gnt <= sel;
               end
            end
            arb_granted: state <= arb_tenure;               // master starts ts now
            arb_tenure: begin
               if (aack) begin
                  state <= arb_idle;                        // address bus free for the next one
               end
            end
            default: state <= arb_idle;
         endcase
      end
   end

   assign bg = (state == arb_granted) ? (2'b01 << owner) : 2'b00;

   assign push      = (state == arb_tenure) && aack;
   assign last_beat = (q_cnt != 2'd0) && ta
                      && (beat == (q_bst[0] ? beat_w'(burst_beats - 1) : '0));
   assign q_cnt_pop = q_cnt - 2'(last_beat);
   assign wr_slot   = (q_cnt_pop != 2'd0);                  // land behind a waiting entry

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_cnt <= 2'd0;
         beat  <= '0;
      end else begin
         q_cnt <= q_cnt_pop + 2'(push);
         if (last_beat) begin
            beat <= '0;
         end else if (ta && q_cnt != 2'd0) begin
            beat <= beat + 1'b1;
         end
      end
   end

   // queue payload, a push after a pop overrides slot 0
   always_ff @(posedge clk) begin
      if (last_beat) begin
         q_idx[0] <= q_idx[1];
         q_bst[0] <= q_bst[1];
      end
      if (push) begin
         q_idx[wr_slot] <= owner;
         q_bst[wr_slot] <= burst;
      end
   end

   // dbg holds through the tenure, hands over right after the last ta
   assign dbg = (q_cnt != 2'd0) ? (2'b01 << q_idx[0]) : 2'b00;

endmodule

//--- logic/bus_master_port.sv
// one bus master: takes a command, requests the bus, runs address and data tenures
`timescale 1ns/100ps

module bus_master_port import bus60x_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_valid,
   input  cmd_s              cmd,
   output logic              cmd_ready,
   output logic              br,
   input  logic              bg,
   input  logic              dbg,                           // own data bus grant
   input  logic              aack,
   input  logic              ta,
   input  logic [data_w-1:0] rdata_bus,                     // read data from memory
   output addr_bus_s         abus,
   output data_bus_s         dbus,
   output logic              done,
   output logic [data_w-1:0] rdata
);

   typedef enum logic [2:0] {
      mp_idle,                                              // ready for a command
      mp_req,                                               // br up, waiting bg
      mp_start,                                             // ts cycle
      mp_addr,                                              // address held until aack
      mp_data                                               // waiting dbg, then beats
   } mp_state_e;

   mp_state_e         state;
   cmd_s              cmd_q;                                // latched command
   logic [beat_w-1:0] beat;
   logic              wr;
   logic              my_ta;                                // ta for our own tenure
   logic              last;

   assign wr        = is_write(cmd_q.tt);
   assign my_ta     = ta && dbg && (state == mp_data);
   assign last      = beat == (is_burst(cmd_q.tt) ? beat_w'(burst_beats - 1) : '0);
   assign cmd_ready = (state == mp_idle);
   assign br        = (state == mp_req);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= mp_idle;
         beat  <= '0;
         done  <= 1'b0;
      end else begin
         done <= my_ta && (!wr || last);                    // every read beat, last write beat
         case (state)
            mp_idle: begin
               beat <= '0;
               if (cmd_valid) begin
                  state <= mp_req;
               end
            end
            mp_req:   if (bg) state <= mp_start;
            mp_start: state <= mp_addr;
            mp_addr:  if (aack) state <= mp_data;
            mp_data: begin
               if (my_ta) begin
                  if (last) begin
                     state <= mp_idle;
                  end else begin
                     beat <= beat + 1'b1;                   // next write word
                  end
               end
            end
            default: state <= mp_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_valid && cmd_ready) begin
         cmd_q <= cmd;
      end
      if (my_ta && !wr) begin
         rdata <= rdata_bus;
      end
   end

   // drive zeros when not owner so the OR merge sees only the owner
   always_comb begin
      abus = '0;
      if (state == mp_start || state == mp_addr) begin
         abus.ts   = (state == mp_start);
         abus.abb  = 1'b1;
         abus.tt   = cmd_q.tt;
         abus.addr = cmd_q.addr;
         abus.ap   = addr_parity(cmd_q.addr);
      end
   end

   always_comb begin
      dbus = '0;
      if (state == mp_data && dbg) begin
         dbus.dbb       = 1'b1;
         dbus.with_data = wr;
         dbus.data      = wr ? cmd_q.wdata[beat] : '0;
      end
   end

endmodule

//--- logic/bus_combine.sv
// merges the masters' address and data drives onto the shared bus and flags address parity errors
`timescale 1ns/100ps

module bus_combine import bus60x_pkg::*; (
   input  addr_bus_s abus0,                             // master 0 address drive
   input  addr_bus_s abus1,                             // master 1 address drive
   input  data_bus_s dbus0,
   input  data_bus_s dbus1,
   output addr_bus_s abus,                              // merged address bus
   output data_bus_s dbus,                              // merged data bus
   output logic      ape                                // address parity error
);

   logic [3:0] ap_calc;                                 // parity rebuilt from the merged address
   logic [3:0] ap_err;                                  // per byte mismatch

   // idle masters drive all zeros, so OR stands in for the wired bus
   always_comb begin
      abus = addr_bus_s'(abus0 | abus1);
      dbus = data_bus_s'(dbus0 | dbus1);
   end

   assign ap_calc = addr_parity(abus.addr);
   assign ap_err  = ap_calc ^ abus.ap;

   // only checked in the ts cycle, when the address is fresh
   assign ape = abus.ts && (|ap_err);

endmodule

//--- logic/mem_target.sv
// memory slave on the bus: acknowledges addresses after a fixed delay and serves data beats
`timescale 1ns/100ps

module mem_target import bus60x_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  addr_bus_s         abus,                          // merged address bus
   input  data_bus_s         dbus,                          // merged data bus
   input  logic [1:0]        dbg,
   output logic              aack,
   output logic              ta,
   output logic [data_w-1:0] rdata_bus
);

   logic [data_w-1:0] mem_q [mem_words];                    // storage, no reset
   logic              a_pend;                               // address tenure awaiting aack
   logic [lat_w-1:0]  a_cnt;                                // cycles left to aack
   logic [addr_w-1:0] q_addr [2];                           // acked tenures, [0] is head
   tt_e               q_tt [2];
   logic [1:0]        q_cnt;
   logic [1:0]        q_cnt_pop;
   logic              d_active;                             // head tenure issuing ta
   logic [beat_w-1:0] beat;
   logic              last_beat;
   logic              wr_slot;
   logic [widx_w-1:0] idx;                                  // word for the current beat

   // a full queue means one tenure running and one waiting, so hold aack off
   assign aack = a_pend && (a_cnt == '0) && (q_cnt != 2'd2);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a_pend <= 1'b0;
         a_cnt  <= '0;
      end else if (abus.ts) begin
         a_pend <= 1'b1;
         a_cnt  <= lat_w'(aack_lat - 1);
      end else if (a_pend) begin
         if (a_cnt != '0) begin
            a_cnt <= a_cnt - 1'b1;
         end else if (aack) begin
            a_pend <= 1'b0;
         end
      end
   end

   assign ta        = d_active;
   assign last_beat = d_active
                      && (beat == (is_burst(q_tt[0]) ? beat_w'(burst_beats - 1) : '0));
   assign q_cnt_pop = q_cnt - 2'(last_beat);
   assign wr_slot   = (q_cnt_pop != 2'd0);

   // ta starts the cycle after dbg, stops after 1 or burst_beats beats
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_cnt    <= 2'd0;
         d_active <= 1'b0;
         beat     <= '0;
      end else begin
         q_cnt <= q_cnt_pop + 2'(aack);
         if (last_beat) begin
            d_active <= 1'b0;
            beat     <= '0;
         end else if (d_active) begin
            beat <= beat + 1'b1;
         end else if (|dbg && q_cnt != 2'd0) begin
            d_active <= 1'b1;                               // grant seen, beats from next cycle
         end
      end
   end

   // address is still held on the bus in the aack cycle
   always_ff @(posedge clk) begin
      if (last_beat) begin
         q_addr[0] <= q_addr[1];
         q_tt[0]   <= q_tt[1];
      end
      if (aack) begin
         q_addr[wr_slot] <= abus.addr;
         q_tt[wr_slot]   <= abus.tt;
      end
   end

   // burst words step by one double word and wrap at mem_words
   assign idx = q_addr[0][dw_lsb +: widx_w] + widx_w'(beat);

   always_ff @(posedge clk) begin
      if (ta && dbus.dbb && dbus.with_data) begin
         mem_q[idx] <= dbus.data;
      end
   end

   assign rdata_bus = (ta && !is_write(q_tt[0])) ? mem_q[idx] : '0;

endmodule

//--- logic/bus60x_top.sv
// bus system top: two master ports, bus merge, arbiter and memory on one 60x style bus
`timescale 1ns/100ps

module bus60x_top import bus60x_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [1:0]        cmd_valid,
   input  cmd_s              cmd0,
   input  cmd_s              cmd1,
   output logic [1:0]        cmd_ready,
   output logic [1:0]        done,
   output logic [data_w-1:0] rdata0,
   output logic [data_w-1:0] rdata1,
   output logic              ape
);

   logic [1:0]        br;
   logic [1:0]        bg;
   logic [1:0]        dbg;
   logic              aack;
   logic              ta;
   logic              burst;                                // merged tt is a burst
   logic [data_w-1:0] rdata_bus;
   addr_bus_s         abus0;
   addr_bus_s         abus1;
   addr_bus_s         abus;                                 // merged address bus
   data_bus_s         dbus0;
   data_bus_s         dbus1;
   data_bus_s         dbus;                                 // merged data bus

   assign burst = is_burst(abus.tt);

   bus_master_port u_mp0 (
      .clk, .rst_n,
      .cmd_valid (cmd_valid[0]), .cmd (cmd0), .cmd_ready (cmd_ready[0]),
      .br (br[0]), .bg (bg[0]), .dbg (dbg[0]), .aack, .ta, .rdata_bus,
      .abus (abus0), .dbus (dbus0), .done (done[0]), .rdata (rdata0)
   );

   bus_master_port u_mp1 (
      .clk, .rst_n,
      .cmd_valid (cmd_valid[1]), .cmd (cmd1), .cmd_ready (cmd_ready[1]),
      .br (br[1]), .bg (bg[1]), .dbg (dbg[1]), .aack, .ta, .rdata_bus,
      .abus (abus1), .dbus (dbus1), .done (done[1]), .rdata (rdata1)
   );

   bus_combine u_comb (.abus0, .abus1, .dbus0, .dbus1, .abus, .dbus, .ape);

   bus_arbiter u_arb (
      .clk, .rst_n, .br, .ts (abus.ts), .abb (abus.abb),
      .aack, .ta, .burst, .bg, .dbg
   );

   mem_target u_mem (.clk, .rst_n, .abus, .dbus, .dbg, .aack, .ta, .rdata_bus);

endmodule

//--- tests/bus60x_tb.sv
// self-checking testbench for the 60x bus system; runs a command table through both masters
`timescale 1ns/100ps

module bus60x_tb import bus60x_pkg::*; ();

   localparam int rst_cycles   = 10;
   localparam int wd_per_entry = 200;                       // watchdog budget per table entry
   localparam int rnd_pairs    = 12;                        // random entries per master

   typedef struct packed {
      logic                               mst;              // issuing master
      tt_e                                tt;
      logic [addr_w-1:0]                  addr;
      logic [burst_beats-1:0][data_w-1:0] wdata;
      logic [burst_beats-1:0][data_w-1:0] rexp;             // expected read beats
      logic                               with_next;        // next entry goes out with this one
   } entry_s;

   logic              clk;
   logic              rst_n;
   logic [1:0]        cmd_valid;
   cmd_s              cmd0;
   cmd_s              cmd1;
   logic [1:0]        cmd_ready;
   logic [1:0]        done;
   logic [data_w-1:0] rdata0;
   logic [data_w-1:0] rdata1;
   logic              ape;

   entry_s            tbl [$];
   logic [data_w-1:0] shadow [mem_words];                   // expected memory contents
   bit                written [mem_words];
   logic [63:0]       rnd_state;
   logic [data_w-1:0] got0 [$];                             // read beats seen per master
   logic [data_w-1:0] got1 [$];
   int                order [$];                            // master index of each done pulse
   int                errors;
   int                checks;
   bit                tbl_ready;
   bit                rr_last;                              // model of the last granted master

   bus60x_top DUT (
      .clk, .rst_n, .cmd_valid, .cmd0, .cmd1, .cmd_ready,
      .done, .rdata0, .rdata1, .ape
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                                // 8 ns period
   end

   function automatic logic [63:0] xorshift(input logic [63:0] s);
      logic [63:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 7);
      return x ^ (x << 17);
   endfunction

   function automatic logic [63:0] next_rand();
      rnd_state = xorshift(rnd_state);
      return rnd_state;
   endfunction

   function automatic int beats_of(input tt_e tt);
      return (tt == tt_read_burst || tt == tt_write_burst) ? 4 : 1;
   endfunction

   function automatic bit writes(input tt_e tt);
      return (tt == tt_write || tt == tt_write_burst);
   endfunction

   // double word index, wrapped to the memory depth
   function automatic int word_of(input logic [addr_w-1:0] addr);
      return int'((addr >> 3) % mem_words);
   endfunction

   task automatic add_entry(input logic mst, input tt_e tt, input logic [addr_w-1:0] addr,
                            input logic with_next);
      entry_s e;
      int     w;
      e = '0;
      e.mst = mst;
      e.tt = tt;
      e.addr = addr;
      e.with_next = with_next;
      for (int k = 0; k < beats_of(tt); k++) begin
         w = (word_of(addr) + k) % mem_words;               // bursts wrap at the top
         if (writes(tt)) begin
            e.wdata[k] = next_rand();
            shadow[w]  = e.wdata[k];
            written[w] = 1'b1;
         end else begin
            e.rexp[k] = shadow[w];
         end
      end
      tbl.push_back(e);
   endtask

   // master 0 stays in words 0..122, master 1 in 128..250, so a pair never overlaps
   task automatic add_random(input logic mst, input logic with_next);
      logic [63:0] r;
      tt_e         tt;
      int          w;
      bit          fresh;
      r = next_rand();
      fresh = 1'b0;
      case (r[1:0])
         2'd0:    tt = tt_write;
         2'd1:    tt = tt_write_burst;
         2'd2:    tt = tt_read;
         default: tt = tt_read_burst;
      endcase
      w = (mst ? 128 : 0) + int'(r[15:8] % 120);
      if (!writes(tt)) begin
         for (int k = 0; k < beats_of(tt); k++) begin
            if (!written[w + k]) fresh = 1'b1;              // never written, so unknown
         end
         if (fresh) tt = (tt == tt_read) ? tt_write : tt_write_burst;
      end
      add_entry(mst, tt, {r[52:32], 8'(w), 3'b000}, with_next);  // random alias bits on top
   endtask

   task automatic build_table();
      rnd_state = 64'd86301;
      for (int w = 0; w < mem_words; w++) written[w] = 1'b0;
      add_entry(1'b0, tt_write, 32'h0000_0040, 1'b1);       // tie right after reset
      add_entry(1'b1, tt_write, 32'h0000_0440, 1'b0);
      add_entry(1'b0, tt_read, 32'h0000_0440, 1'b1);        // cross reads, tie again
      add_entry(1'b1, tt_read, 32'h0000_0040, 1'b0);
      add_entry(1'b0, tt_write, 32'h0000_0100, 1'b0);       // single write then read
      add_entry(1'b0, tt_read, 32'h0000_0100, 1'b0);
      add_entry(1'b0, tt_write_burst, 32'h0000_07f0, 1'b0); // words 254, 255, 0, 1
      add_entry(1'b0, tt_read_burst, 32'h1230_07f0, 1'b0);  // same words through an alias
      add_entry(1'b0, tt_read_burst, 32'h0000_07f0, 1'b1);  // master 1 should win this tie
      add_entry(1'b1, tt_write_burst, 32'h0000_0500, 1'b0);
      for (int p = 0; p < rnd_pairs; p++) begin
         add_random(1'b0, 1'b1);
         add_random(1'b1, 1'b0);
      end
   endtask

   task automatic drive_cmd(input entry_s e);
      cmd_s c;
      c.tt    = e.tt;
      c.addr  = e.addr;
      c.wdata = e.wdata;
      if (e.mst) begin
         cmd1         <= c;
         cmd_valid[1] <= 1'b1;
      end else begin
         cmd0         <= c;
         cmd_valid[0] <= 1'b1;
      end
   endtask

   // gather done pulses and read beats until both masters reach their counts
   task automatic collect(input int n0, input int n1);
      got0.delete();
      got1.delete();
      order.delete();
      while (got0.size() < n0 || got1.size() < n1) begin
         @(negedge clk);
         if (done[0]) begin
            got0.push_back(rdata0);
            order.push_back(0);
         end
         if (done[1]) begin
            got1.push_back(rdata1);
            order.push_back(1);
         end
      end
      checks += 3;
      if (got0.size() != n0 || got1.size() != n1) begin
         errors++;
         $display("[ERROR] done pulse counts = %h/%h, expected %h/%h",
                  got0.size(), got1.size(), n0, n1);
      end
      if ((n0 > 0 && !cmd_ready[0]) || (n1 > 0 && !cmd_ready[1])) begin
         errors++;
         $display("[ERROR] cmd_ready = %h after the last done", cmd_ready);
      end
      @(negedge clk);
      if (done !== 2'b00) begin                             // pulse lasts one cycle
         errors++;
         $display("[ERROR] done = %h, expected 0", done);
      end
   endtask

   task automatic check_reads(input entry_s e);
      logic [data_w-1:0] got;
      for (int k = 0; k < beats_of(e.tt); k++) begin
         if (!writes(e.tt)) begin
            checks++;
            got = 'x;
            if (e.mst && k < got1.size()) got = got1[k];
            if (!e.mst && k < got0.size()) got = got0[k];
            if (got !== e.rexp[k]) begin
               errors++;
               $display("[ERROR] rdata%0d beat %0d = %h, expected %h", e.mst, k, got, e.rexp[k]);
            end
         end
      end
   endtask

   task automatic run_step(input int i, input bit paired);
      entry_s a;
      entry_s b;
      int     n [2];
      int     first;
      a = tbl[i];
      b = paired ? tbl[i + 1] : '0;
      n[0] = 0;
      n[1] = 0;
      n[a.mst] = writes(a.tt) ? 1 : beats_of(a.tt);
      @(posedge clk);
      drive_cmd(a);
      if (paired) begin
         n[b.mst] = writes(b.tt) ? 1 : beats_of(b.tt);
         drive_cmd(b);
      end
      @(posedge clk);
      cmd_valid <= 2'b00;                                   // accepted on this edge
      collect(n[0], n[1]);
      if (paired) begin
         first = rr_last ? 0 : 1;                           // loser keeps the last grant
         checks++;
         if (order.size() == 0 || order[0] != first) begin
            errors++;
            $display("entry %0d: master %0d should have finished first", i, first);
         end
         check_reads(b);
      end else begin
         rr_last = a.mst;
      end
      check_reads(a);
   endtask

   always @(negedge clk) begin
      if (rst_n && ape !== 1'b0) begin
         errors++;
         $display("[ERROR] ape = %h, expected 0", ape);
      end
   end

   initial begin
      wait (tbl_ready);
      repeat (rst_cycles + wd_per_entry * tbl.size()) @(posedge clk);
      $display("timeout: the command table did not finish in time");
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      int i;
      rst_n     = 1'b0;
      cmd_valid = 2'b00;
      cmd0      = '0;
      cmd1      = '0;
      errors    = 0;
      checks    = 0;
      rr_last   = 1'b1;                                     // master 0 wins the first tie
      build_table();
      tbl_ready = 1'b1;
      repeat (rst_cycles) @(posedge clk);
      @(negedge clk);
      checks++;
      if (cmd_ready !== 2'b11 || done !== 2'b00) begin
         errors++;
         $display("[ERROR] cmd_ready = %h, done = %h, expected 3 and 0", cmd_ready, done);
      end
      @(posedge clk);
      rst_n <= 1'b1;
      i = 0;
      while (i < tbl.size()) begin
         run_step(i, tbl[i].with_next);
         i += tbl[i].with_next ? 2 : 1;
      end
      repeat (4) @(posedge clk);
      $display("entries: %0d, checks: %0d, errors: %0d", tbl.size(), checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- build.f
logic/bus60x_pkg.sv
logic/bus_arbiter.sv
logic/bus_master_port.sv
logic/bus_combine.sv
logic/mem_target.sv
logic/bus60x_top.sv
tests/bus60x_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the bus testbench with Verilator, run it and judge the run from its log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   --top-module bus60x_tb -f build.f -o bus60x_sim

./obj_dir/bus60x_sim | tee sim.log

if grep -qx '>>> PASS' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
